//--- tb.f
logic/video_pkg.sv
logic/video_sig_gen.sv
logic/frame_latch.sv
logic/note_tracker.sv
logic/dry_gen.sv
logic/delay_gen.sv
logic/gui_overlay.sv
logic/video_processor.sv
tests/video_processor_checker.sv
tests/video_processor_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module video_processor_tb -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep "Test completed successfully" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation did not pass"; exit 1; }

//--- tests/video_processor_tb.sv
`timescale 1ns/1ps

module video_processor_tb;

  typedef struct packed {
    video_pkg::raster_t pos;
    video_pkg::levels_t levels;
    video_pkg::knob_t   knobs;
  } stage_t;

  logic              clk_pixel;
  logic              rst;
  video_pkg::midi_t  midi;
  video_pkg::knob_t  knobs;
  video_pkg::pixel_t pixel_to_hdmi;
  logic              active_draw_to_hdmi;
  logic              h_sync_to_hdmi;
  logic              v_sync_to_hdmi;

  // reference model state
  video_pkg::raster_t m_raster;
  video_pkg::levels_t m_levels;
  video_pkg::levels_t snap_levels;
  video_pkg::knob_t   snap_knobs;
  stage_t             hist [5];
  int                 run_len;
  video_pkg::pixel_t  exp_pixel;
  logic               exp_active;
  logic               exp_hsync;
  logic               exp_vsync;

  video_processor UUT (
    .clk_pixel          (clk_pixel),
    .rst                (rst),
    .midi               (midi),
    .knobs              (knobs),
    .pixel_to_hdmi      (pixel_to_hdmi),
    .active_draw_to_hdmi(active_draw_to_hdmi),
    .h_sync_to_hdmi     (h_sync_to_hdmi),
    .v_sync_to_hdmi     (v_sync_to_hdmi)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #50 clk_pixel = ~clk_pixel;
  end

  // bar level at a spot and 0 where the spot is dark
  function automatic logic [7:0] bar_at(input int col, input int row,
                                        input video_pkg::levels_t lv);
    logic [1:0] band;
    int         height;
    bar_at = 8'd0;
    if (col < video_pkg::h_active && row < video_pkg::v_active) begin
      band = 2'(col / video_pkg::band_w);
      height = int'(lv.level[band]) / 16;
      if (video_pkg::v_active - 1 - row < height) begin
        bar_at = lv.level[band];
      end
    end
  endfunction

  function automatic video_pkg::pixel_t expected_pixel(input video_pkg::raster_t pos,
                                                       input video_pkg::levels_t lv,
                                                       input video_pkg::knob_t kn);
    int h;
    int v;
    int offset;
    int dry;
    int echo;
    int diff;
    h = int'(pos.h_count);
    v = int'(pos.v_count);
    offset = int'(kn.delay_rate[2:0]);
    expected_pixel = '0;
    if (h < video_pkg::h_active && v < video_pkg::v_active) begin
      if (v == 0 && h < int'(kn.volume) / 32) begin
        expected_pixel = '1;
      end else begin
        dry = int'(bar_at(h, v, lv));
        echo = 0;
        if (h >= offset) begin
          echo = int'(bar_at(h - offset, v, lv));
        end
        echo = (echo * int'(kn.delay_wet[9:2])) / 256;
        diff = (dry > echo) ? dry - echo : echo - dry;
        expected_pixel = {3{8'(diff)}};
      end
    end
  endfunction

  task automatic check_pixel(input string name, input video_pkg::pixel_t expected,
                             input video_pkg::pixel_t actual);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "pixel mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  // reference model steps once per rising edge
  always @(posedge clk_pixel) begin : model
    logic [1:0]       inst;
    int               h;
    int               v;
    video_pkg::knob_t pipe_knobs;
    if (rst) begin
      m_raster = '0;
      m_levels = '0;
      snap_levels = '0;
      snap_knobs = '0;
      run_len = 0;
    end else begin
      if (m_raster.new_frame) begin
        snap_levels = m_levels;
        snap_knobs = knobs;
      end
      for (inst = 2'd0; inst < 2'd3; inst++) begin
        if (midi.valid && int'(midi.key) % 3 == int'(inst)) begin
          m_levels.level[inst] = (midi.velocity == 7'd0) ? 8'd0 : 8'(int'(midi.velocity) * 2);
        end else if (m_raster.new_frame) begin
          m_levels.level[inst] = (m_levels.level[inst] > 8'(video_pkg::decay_step)) ?
                                 m_levels.level[inst] - 8'(video_pkg::decay_step) : 8'd0;
        end
      end
      if (m_raster.h_count == 5'(video_pkg::h_total - 1)) begin
        m_raster.h_count = 5'd0;
        if (m_raster.v_count == 5'(video_pkg::v_total - 1)) begin
          m_raster.v_count = 5'd0;
        end else begin
          m_raster.v_count = m_raster.v_count + 5'd1;
        end
      end else begin
        m_raster.h_count = m_raster.h_count + 5'd1;
      end
      m_raster.new_frame = (m_raster.h_count == 5'd0) && (m_raster.v_count == 5'd0);
      if (run_len < 4) begin
        run_len++;
      end
    end
    m_raster.active_draw = (m_raster.h_count < 5'(video_pkg::h_active)) &&
                           (m_raster.v_count < 5'(video_pkg::v_active));
    hist[4] = hist[3];
    hist[3] = hist[2];
    hist[2] = hist[1];
    hist[1] = hist[0];
    hist[0].pos = m_raster;
    hist[0].levels = snap_levels;
    hist[0].knobs = snap_knobs;
    if (run_len < 4) begin
      exp_pixel = '0;
      exp_active = 1'b0;
      exp_hsync = 1'b0;
      exp_vsync = 1'b0;
    end else begin
      // each stage reads its knob as the pixel passes through it
      pipe_knobs.volume = hist[1].knobs.volume;
      pipe_knobs.delay_wet = hist[3].knobs.delay_wet;
      pipe_knobs.delay_rate = hist[4].knobs.delay_rate;
      h = int'(hist[4].pos.h_count);
      v = int'(hist[4].pos.v_count);
      exp_pixel = expected_pixel(hist[4].pos, hist[4].levels, pipe_knobs);
      exp_active = (h < video_pkg::h_active) && (v < video_pkg::v_active);
      exp_hsync = (h >= video_pkg::h_active + video_pkg::h_front) &&
                  (h < video_pkg::h_active + video_pkg::h_front + video_pkg::h_sync);
      exp_vsync = (v >= video_pkg::v_active + video_pkg::v_front) &&
                  (v < video_pkg::v_active + video_pkg::v_front + video_pkg::v_sync);
    end
  end

  always @(negedge clk_pixel) begin
    check_pixel("pixel_to_hdmi", exp_pixel, pixel_to_hdmi);
    check_flag("active_draw_to_hdmi", exp_active, active_draw_to_hdmi);
    check_flag("h_sync_to_hdmi", exp_hsync, h_sync_to_hdmi);
    check_flag("v_sync_to_hdmi", exp_vsync, v_sync_to_hdmi);
  end

  task automatic next_cycle();
    @(posedge clk_pixel);
    #10;
  endtask

  task automatic send_note(input logic [6:0] key, input logic [6:0] velocity);
    midi.valid = 1'b1;
    midi.key = key;
    midi.velocity = velocity;
    next_cycle();
    midi = '0;
  endtask

  // returns just after the rising edge of vsync
  task automatic wait_frame();
    int   waited;
    logic prev;
    waited = 0;
    prev = v_sync_to_hdmi;
    while (!(v_sync_to_hdmi && !prev)) begin
      prev = v_sync_to_hdmi;
      next_cycle();
      waited++;
      if (waited > 3 * video_pkg::h_total * video_pkg::v_total) begin
        $display("Timeout: no vertical sync seen within three frames");
        $display("Test failed");
        $fatal(1, "frame wait timed out");
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    midi = '0;
    knobs = '0;
    void'($urandom(32'hd5ad));
    repeat (4) next_cycle();
    rst = 1'b0;
    repeat (8) next_cycle();
    wait_frame();
    wait_frame();
    // note-ons on keys 0 to 5 and then a note-off
    for (int key = 0; key < 6; key++) begin
      send_note(7'(key), 7'($urandom_range(127, 1)));
    end
    wait_frame();
    wait_frame();
    send_note(7'd4, 7'd0);
    wait_frame();
    wait_frame();
    // bars decay away without further events
    repeat (18) wait_frame();
    // echo knobs move in the middle of a frame
    repeat (5) begin
      for (int key = 0; key < 3; key++) begin
        send_note(7'(key), 7'($urandom_range(127, 1)));
      end
      wait_frame();
      repeat (video_pkg::h_total * 8) next_cycle();
      knobs.delay_wet = 10'($urandom_range(1023, 0));
      knobs.delay_rate = 10'($urandom_range(1023, 0));
      wait_frame();
      wait_frame();
    end
    // volume meter at zero, full and random settings
    knobs.volume = 10'd0;
    wait_frame();
    wait_frame();
    knobs.volume = 10'h3ff;
    wait_frame();
    wait_frame();
    repeat (3) begin
      knobs.volume = 10'($urandom_range(1023, 0));
      wait_frame();
      wait_frame();
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- tests/video_processor_checker.sv
`timescale 1ns/1ps

module video_processor_checker (
  input logic               clk_pixel,
  input logic               rst,
  input video_pkg::raster_t raster,
  input video_pkg::pixel_t  pixel_to_hdmi,
  input logic               active_draw_to_hdmi,
  input logic               h_sync_to_hdmi
);

  // hsync only in blanking
  property sync_outside_active;
    @(posedge clk_pixel) disable iff (rst)
      !(h_sync_to_hdmi && active_draw_to_hdmi);
  endproperty

  property black_when_blank;
    @(posedge clk_pixel) disable iff (rst)
      !active_draw_to_hdmi |-> (pixel_to_hdmi == '0);
  endproperty

  property single_frame_pulse;
    @(posedge clk_pixel) disable iff (rst)
      raster.new_frame |=> !raster.new_frame;
  endproperty

  sync_outside_active_a: assert property (sync_outside_active)
    else $error("horizontal sync asserted during active drawing");

  black_when_blank_a: assert property (black_when_blank)
    else $error("nonzero pixel outside the active area");

  single_frame_pulse_a: assert property (single_frame_pulse)
    else $error("new_frame pulse longer than one cycle");

endmodule

bind video_processor video_processor_checker u_checker (
  .clk_pixel          (clk_pixel),
  .rst                (rst),
  .raster             (raster),
  .pixel_to_hdmi      (pixel_to_hdmi),
  .active_draw_to_hdmi(active_draw_to_hdmi),
  .h_sync_to_hdmi     (h_sync_to_hdmi)
);

//--- logic/video_processor.sv
`timescale 1ns/1ps

module video_processor (
  input  logic              clk_pixel,
  input  logic              rst,
  input  video_pkg::midi_t  midi,
  input  video_pkg::knob_t  knobs,
  output video_pkg::pixel_t pixel_to_hdmi,
  output logic              active_draw_to_hdmi,
  output logic              h_sync_to_hdmi,
  output logic              v_sync_to_hdmi
);

  video_pkg::raster_t raster;
  video_pkg::levels_t live_levels;
  video_pkg::levels_t frame_levels;
  video_pkg::knob_t   frame_knobs;

  logic [7:0] dry_intensity;
  logic [7:0] dry_intensity_d;
  logic [7:0] delay_intensity;
  logic [7:0] total_intensity;

  video_sig_gen u_sig_gen (
    .clk_pixel(clk_pixel),
    .rst      (rst),
    .raster   (raster)
  );

  note_tracker u_note_tracker (
    .clk_pixel  (clk_pixel),
    .rst        (rst),
    .midi       (midi),
    .new_frame  (raster.new_frame),
    .live_levels(live_levels)
  );

  // drawing sees one set of levels and knobs per frame
  frame_latch #(
    .payload_t(video_pkg::levels_t)
  ) u_level_latch (
    .clk_pixel(clk_pixel),
    .rst      (rst),
    .new_frame(raster.new_frame),
    .d        (live_levels),
    .q        (frame_levels)
  );

  frame_latch #(
    .payload_t(video_pkg::knob_t)
  ) u_knob_latch (
    .clk_pixel(clk_pixel),
    .rst      (rst),
    .new_frame(raster.new_frame),
    .d        (knobs),
    .q        (frame_knobs)
  );

  dry_gen u_dry_gen (
    .clk_pixel(clk_pixel),
    .rst      (rst),
    .raster   (raster),
    .levels   (frame_levels),
    .intensity(dry_intensity)
  );

  delay_gen u_delay_gen (
    .clk_pixel(clk_pixel),
    .rst      (rst),
    .raster   (raster),
    .levels   (frame_levels),
    .wet      (frame_knobs.delay_wet),
    .rate     (frame_knobs.delay_rate),
    .intensity(delay_intensity)
  );

  // dry path is one stage shorter than the echo
  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      dry_intensity_d <= '0;
      total_intensity <= '0;
    end else begin
      dry_intensity_d <= dry_intensity;
      if (dry_intensity_d > delay_intensity) begin
        total_intensity <= dry_intensity_d - delay_intensity;
      end else begin
        total_intensity <= delay_intensity - dry_intensity_d;
      end
    end
  end

  gui_overlay u_gui_overlay (
    .clk_pixel          (clk_pixel),
    .rst                (rst),
    .raster             (raster),
    .intensity          (total_intensity),
    .volume             (frame_knobs.volume),
    .pixel_to_hdmi      (pixel_to_hdmi),
    .active_draw_to_hdmi(active_draw_to_hdmi),
    .h_sync_to_hdmi     (h_sync_to_hdmi),
    .v_sync_to_hdmi     (v_sync_to_hdmi)
  );

endmodule

//--- logic/gui_overlay.sv
`timescale 1ns/1ps

module gui_overlay (
  input  logic               clk_pixel,
  input  logic               rst,
  input  video_pkg::raster_t raster,
  input  logic [7:0]         intensity,
  input  logic [9:0]         volume,
  output video_pkg::pixel_t  pixel_to_hdmi,
  output logic               active_draw_to_hdmi,
  output logic               h_sync_to_hdmi,
  output logic               v_sync_to_hdmi
);

  // position lines up with intensity after three stages
  video_pkg::raster_t [2:0] raster_d;
  video_pkg::raster_t       pos;
  logic                     h_sync_now;
  logic                     v_sync_now;
  logic                     meter_lit;

  assign pos = raster_d[2];

  assign h_sync_now = (pos.h_count >= 5'(video_pkg::h_active + video_pkg::h_front)) &&
                      (pos.h_count < 5'(video_pkg::h_active + video_pkg::h_front +
                                        video_pkg::h_sync));
  assign v_sync_now = (pos.v_count >= 5'(video_pkg::v_active + video_pkg::v_front)) &&
                      (pos.v_count < 5'(video_pkg::v_active + video_pkg::v_front +
                                        video_pkg::v_sync));

  // volume meter on the top row
  assign meter_lit = (pos.v_count == 5'd0) &&
                     (pos.h_count < 5'(volume / 10'(video_pkg::meter_div)));

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      raster_d <= '0;
      pixel_to_hdmi <= '0;
      active_draw_to_hdmi <= 1'b0;
      h_sync_to_hdmi <= 1'b0;
      v_sync_to_hdmi <= 1'b0;
    end else begin
      raster_d <= {raster_d[1:0], raster};
      active_draw_to_hdmi <= pos.active_draw;
      h_sync_to_hdmi <= h_sync_now;
      v_sync_to_hdmi <= v_sync_now;
      if (!pos.active_draw) begin
        pixel_to_hdmi <= '0;
      end else if (meter_lit) begin
        pixel_to_hdmi <= '1;
      end else begin
        pixel_to_hdmi <= {intensity, intensity, intensity};
      end
    end
  end

endmodule

//--- logic/delay_gen.sv
`timescale 1ns/1ps

module delay_gen (
  input  logic               clk_pixel,
  input  logic               rst,
  input  video_pkg::raster_t raster,
  input  video_pkg::levels_t levels,
  input  logic [9:0]         wet,
  input  logic [9:0]         rate,
  output logic [7:0]         intensity
);

  logic [2:0]  offset;
  logic [4:0]  src_col;
  logic        in_range;
  logic [7:0]  echo_bar;
  logic [7:0]  echo_level;
  logic [15:0] product;

  assign offset = rate[2:0];
  assign in_range = raster.h_count >= {2'b00, offset};
  assign src_col = raster.h_count - {2'b00, offset};

  // echo reads the bar image from a column further left
  assign echo_bar = video_pkg::bar_value(src_col, raster.v_count, levels);

  // wet gain as an 8-bit fraction
  assign product = echo_level * wet[9:2];

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      echo_level <= '0;
      intensity <= '0;
    end else begin
      echo_level <= (raster.active_draw && in_range) ? echo_bar : 8'd0;
      intensity <= product[15:8];
    end
  end

endmodule

//--- logic/dry_gen.sv
`timescale 1ns/1ps

module dry_gen (
  input  logic               clk_pixel,
  input  logic               rst,
  input  video_pkg::raster_t raster,
  input  video_pkg::levels_t levels,
  output logic [7:0]         intensity
);

  logic [7:0] bar;

  // bars grow up from the bottom line of each band
  assign bar = video_pkg::bar_value(raster.h_count, raster.v_count, levels);

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      intensity <= '0;
    end else begin
      intensity <= raster.active_draw ? bar : 8'd0;
    end
  end

endmodule

//--- logic/note_tracker.sv
`timescale 1ns/1ps

module note_tracker (
  input  logic               clk_pixel,
  input  logic               rst,
  input  video_pkg::midi_t   midi,
  input  logic               new_frame,
  output video_pkg::levels_t live_levels
);

  logic [1:0] inst_sel;
  logic [7:0] note_level;

  // keys cycle through the instruments
  assign inst_sel = 2'(midi.key % 7'd3);
  // zero velocity is a note-off
  assign note_level = (midi.velocity == 7'd0) ? 8'd0 : {midi.velocity, 1'b0};

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      live_levels <= '0;
    end else begin
      for (int i = 0; i < video_pkg::instrument_count; i++) begin
        if (midi.valid && inst_sel == 2'(i)) begin
          live_levels.level[i] <= note_level;
        end else if (new_frame) begin
          // saturating decay
          if (live_levels.level[i] > 8'(video_pkg::decay_step)) begin
            live_levels.level[i] <= live_levels.level[i] - 8'(video_pkg::decay_step);
          end else begin
            live_levels.level[i] <= 8'd0;
          end
        end
      end
    end
  end

endmodule

//--- logic/frame_latch.sv
`timescale 1ns/1ps

module frame_latch #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_pixel,
  input  logic     rst,
  input  logic     new_frame,
  input  payload_t d,
  output payload_t q
);

  // value held for the whole frame
  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      q <= '0;
    end else if (new_frame) begin
      q <= d;
    end
  end

endmodule

//--- logic/video_sig_gen.sv
`timescale 1ns/1ps

module video_sig_gen (
  input  logic               clk_pixel,
  input  logic               rst,
  output video_pkg::raster_t raster
);

  logic [4:0] h_next;
  logic [4:0] v_next;
  logic       h_wrap;
  logic       v_wrap;

  assign h_wrap = (raster.h_count == 5'(video_pkg::h_total - 1));
  assign v_wrap = (raster.v_count == 5'(video_pkg::v_total - 1));

  // next position that the flags below are decoded from
  always_comb begin
    h_next = h_wrap ? 5'd0 : raster.h_count + 5'd1;
    v_next = raster.v_count;
    if (h_wrap) begin
      v_next = v_wrap ? 5'd0 : raster.v_count + 5'd1;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      raster.h_count <= '0;
      raster.v_count <= '0;
      // raster rests on the drawn pixel (0,0) and holds off the frame pulse
      raster.active_draw <= 1'b1;
      raster.new_frame <= 1'b0;
    end else begin
      raster.h_count <= h_next;
      raster.v_count <= v_next;
      raster.active_draw <= (h_next < 5'(video_pkg::h_active)) &&
                            (v_next < 5'(video_pkg::v_active));
      raster.new_frame <= (h_next == 5'd0) && (v_next == 5'd0);
    end
  end

endmodule

//--- logic/video_pkg.sv
package video_pkg;

  // raster geometry in pixels per line and lines per frame
  localparam int h_active = 24;
  localparam int h_front = 2;
  localparam int h_sync = 4;
  localparam int h_total = 32;
  localparam int v_active = 16;
  localparam int v_front = 1;
  localparam int v_sync = 2;
  localparam int v_total = 20;

  localparam int instrument_count = 3;
  localparam int band_w = 8;
  localparam int decay_step = 16;
  // one line of bar for each step of this size in level
  localparam int level_per_line = 16;
  // volume units per lit meter pixel
  localparam int meter_div = 32;

  typedef struct packed {
    logic [4:0] h_count;
    logic [4:0] v_count;
    logic       active_draw;
    logic       new_frame;
  } raster_t;

  typedef struct packed {
    logic [9:0] volume;
    logic [9:0] delay_wet;
    logic [9:0] delay_rate;
  } knob_t;

  typedef struct packed {
    logic [instrument_count-1:0][7:0] level;
  } levels_t;

  typedef struct packed {
    logic       valid;
    logic [6:0] key;
    logic [6:0] velocity;
  } midi_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } pixel_t;

  // level of the bar covering (col, row) and 0 where that spot is unlit
  function automatic logic [7:0] bar_value(input logic [4:0] col, input logic [4:0] row,
                                           input levels_t levels);
    logic [1:0] band;
    logic [7:0] level;
    logic [4:0] from_bottom;
    band = 2'(col / 5'(band_w));
    level = '0;
    from_bottom = '0;
    bar_value = '0;
    if (col < 5'(h_active) && row < 5'(v_active) && band < 2'(instrument_count)) begin
      level = levels.level[band];
      from_bottom = 5'(v_active - 1) - row;
      if (from_bottom < 5'(level / 8'(level_per_line))) begin
        bar_value = level;
      end
    end
  endfunction

endpackage
